// File: common/mini_exu_defines.svh
//////////////////////////////////////////////////
// Mini EXU widths and depths
// Shared by both packages and all stage modules
//////////////////////////////////////////////////

`ifndef MINI_EXU_DEFINES_SVH
`define MINI_EXU_DEFINES_SVH

// Datapath
`define EXU_XLEN 32
`define EXU_RFIDX_W 5

// Long-pipe tracking
`define EXU_OITF_DEPTH 4  // Must be 2**EXU_ITAG_W
`define EXU_ITAG_W 2

`endif

// File: common/exu_instr_pkg.sv
//////////////////////////////////////////////////
// Instruction types for the mini EXU
// Data word, register index and op encoding
//////////////////////////////////////////////////

`default_nettype none

`include "mini_exu_defines.svh"

package exu_instr_pkg;

  typedef logic [`EXU_XLEN-1:0] xlen_t;
  typedef logic [`EXU_RFIDX_W-1:0] rfidx_t;

  // Pre-decoded op from fetch
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_SLT = 3'd5,  // Signed compare
    OP_LD  = 3'd6   // Goes to the long pipe
  } exu_op_e;

endpackage

`default_nettype wire

// File: common/exu_track_pkg.sv
//////////////////////////////////////////////////
// Long-pipe tracking types
//////////////////////////////////////////////////

`default_nettype none

`include "mini_exu_defines.svh"

package exu_track_pkg;

  typedef logic [`EXU_ITAG_W-1:0] itag_t;

  // One outstanding destination
  typedef struct packed {
    logic                    rdwen;
    logic [`EXU_RFIDX_W-1:0] rdidx;
  } oitf_entry_t;

endpackage

`default_nettype wire

// File: hw/exu_regfile.sv
//////////////////////////////////////////////////
// Integer register file, 32 x XLEN
// Two combinational reads, one write, x0 tied low
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "mini_exu_defines.svh"

module exu_regfile
  import exu_instr_pkg::*;
(
  input  wire         clk,
  input  wire         i_rst_n,
  input  wire rfidx_t i_rs1idx,
  input  wire rfidx_t i_rs2idx,
  output xlen_t       o_rs1_dat,
  output xlen_t       o_rs2_dat,
  input  wire         i_wen,
  input  wire rfidx_t i_wrdidx,
  input  wire xlen_t  i_wdat,
  output xlen_t       o_x1
);

  xlen_t rf_r [1:31];  // No flop for x0

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      for (int i = 1; i < 32; i++) begin
        rf_r[i] <= '0;
      end
    end else if (i_wen && (i_wrdidx != '0)) begin
      rf_r[i_wrdidx] <= i_wdat;
    end
  end

  assign o_rs1_dat = (i_rs1idx == '0) ? '0 : rf_r[i_rs1idx];
  assign o_rs2_dat = (i_rs2idx == '0) ? '0 : rf_r[i_rs2idx];
  assign o_x1      = rf_r[1];  // Observation port

endmodule

`default_nettype wire

// File: disp/exu_disp.sv
//////////////////////////////////////////////////
// Dispatch stage
// Checks operands against the OITF, stalls on
// hazards and routes ops to the ALU or long pipe
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "mini_exu_defines.svh"

module exu_disp
  import exu_instr_pkg::*;
  import exu_track_pkg::*;
(
  input  wire          i_valid,
  output logic         o_ready,
  input  wire exu_op_e i_op,
  input  wire rfidx_t  i_rs1idx,
  input  wire rfidx_t  i_rs2idx,
  input  wire rfidx_t  i_rdidx,
  input  wire          i_use_imm,
  input  wire xlen_t   i_imm,
  input  wire xlen_t   i_rs1_dat,
  input  wire xlen_t   i_rs2_dat,
  input  wire          i_oitf_full,
  input  wire          i_match_rs1,
  input  wire          i_match_rs2,
  input  wire          i_match_rd,
  input  wire          i_alu_wbck_ready,
  input  wire          i_agu_cmd_ready,
  output logic         o_oitf_ena,
  output oitf_entry_t  o_oitf_entry,
  output logic         o_alu_valid,
  output exu_op_e      o_alu_op,
  output xlen_t        o_op1,
  output xlen_t        o_op2,
  output logic         o_agu_cmd_valid
);

  logic is_ld;
  logic rs2_en;
  logic rs1_hzd;
  logic rs2_hzd;
  logic rd_hzd;
  logic hazard;

  assign is_ld  = (i_op == OP_LD);
  assign rs2_en = ~i_use_imm;  // Imm forms never read rs2

  //////////////////////////////////////////////////
  // Hazard check, x0 never depends on anything
  assign rs1_hzd = i_match_rs1 & (i_rs1idx != '0);
  assign rs2_hzd = i_match_rs2 & rs2_en & (i_rs2idx != '0);
  assign rd_hzd  = i_match_rd & (i_rdidx != '0);  // WAW on a pending load
  assign hazard  = rs1_hzd | rs2_hzd | rd_hzd;

  //////////////////////////////////////////////////
  // Operands
  assign o_alu_op = i_op;
  assign o_op1    = i_rs1_dat;
  assign o_op2    = i_use_imm ? i_imm : i_rs2_dat;

  // Single-cycle path
  assign o_alu_valid = i_valid & ~is_ld & ~hazard;

  // Long pipe needs a free OITF slot before the command goes out
  assign o_agu_cmd_valid = i_valid & is_ld & ~hazard & ~i_oitf_full;
  assign o_oitf_ena      = o_agu_cmd_valid & i_agu_cmd_ready;
  assign o_oitf_entry    = '{rdwen: (i_rdidx != '0), rdidx: i_rdidx};

  // Ready does not look at i_valid
  assign o_ready = is_ld ? (~hazard & ~i_oitf_full & i_agu_cmd_ready)
                         : (~hazard & i_alu_wbck_ready);

endmodule

`default_nettype wire

// File: oitf/exu_oitf.sv
//////////////////////////////////////////////////
// Outstanding instruction track FIFO
// Holds destinations of loads in flight and
// flags operand matches for dispatch
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "mini_exu_defines.svh"

module exu_oitf
  import exu_instr_pkg::*;
  import exu_track_pkg::*;
#(
  parameter int DEPTH = `EXU_OITF_DEPTH
) (
  input  wire              clk,
  input  wire              i_rst_n,
  input  wire              i_disp_ena,
  input  wire oitf_entry_t i_disp_entry,
  input  wire              i_ret_ena,
  input  wire rfidx_t      i_rs1idx,
  input  wire rfidx_t      i_rs2idx,
  input  wire rfidx_t      i_rdidx,
  output logic             o_match_rs1,
  output logic             o_match_rs2,
  output logic             o_match_rd,
  output itag_t            o_alc_ptr,
  output itag_t            o_ret_ptr,
  output oitf_entry_t      o_ret_entry,
  output logic             o_full,
  output logic             o_empty
);

  logic [`EXU_ITAG_W:0] alc_ptr_r;  // MSB is the wrap bit
  logic [`EXU_ITAG_W:0] ret_ptr_r;
  logic [DEPTH-1:0]     vld_r;
  oitf_entry_t          ent_r [DEPTH];

  assign o_alc_ptr = alc_ptr_r[`EXU_ITAG_W-1:0];
  assign o_ret_ptr = ret_ptr_r[`EXU_ITAG_W-1:0];

  assign o_empty = (alc_ptr_r == ret_ptr_r);
  assign o_full  = (alc_ptr_r[`EXU_ITAG_W] != ret_ptr_r[`EXU_ITAG_W]) &&
                   (o_alc_ptr == o_ret_ptr);

  // Alloc and retire never hit the same slot, full or empty blocks one side
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      alc_ptr_r <= '0;
      ret_ptr_r <= '0;
      vld_r     <= '0;
    end else begin
      if (i_disp_ena) begin
        alc_ptr_r        <= alc_ptr_r + 1'b1;
        vld_r[o_alc_ptr] <= 1'b1;
      end
      if (i_ret_ena) begin
        ret_ptr_r        <= ret_ptr_r + 1'b1;
        vld_r[o_ret_ptr] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_disp_ena) ent_r[o_alc_ptr] <= i_disp_entry;
  end

  assign o_ret_entry = ent_r[o_ret_ptr];  // Head of the queue

  //////////////////////////////////////////////////
  // Compare every live entry with the dispatch indexes
  always_comb begin
    o_match_rs1 = 1'b0;
    o_match_rs2 = 1'b0;
    o_match_rd  = 1'b0;
    for (int i = 0; i < DEPTH; i++) begin
      if (vld_r[i] && ent_r[i].rdwen) begin
        if (ent_r[i].rdidx == i_rs1idx) o_match_rs1 = 1'b1;
        if (ent_r[i].rdidx == i_rs2idx) o_match_rs2 = 1'b1;
        if (ent_r[i].rdidx == i_rdidx)  o_match_rd  = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/exu_alu.sv
//////////////////////////////////////////////////
// Single-cycle ALU
// Also forms the load address for the AGU
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "mini_exu_defines.svh"

module exu_alu
  import exu_instr_pkg::*;
(
  input  wire exu_op_e i_op,
  input  wire xlen_t   i_op1,
  input  wire xlen_t   i_op2,
  output xlen_t        o_result
);

  logic slt;

  assign slt = ($signed(i_op1) < $signed(i_op2));

  always_comb begin
    case (i_op)
      OP_ADD:  o_result = i_op1 + i_op2;
      OP_SUB:  o_result = i_op1 - i_op2;
      OP_AND:  o_result = i_op1 & i_op2;
      OP_OR:   o_result = i_op1 | i_op2;
      OP_XOR:  o_result = i_op1 ^ i_op2;
      OP_SLT:  o_result = {{(`EXU_XLEN-1){1'b0}}, slt};
      // rs1 + imm address
      OP_LD:   o_result = i_op1 + i_op2;
      default: o_result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: wbck/exu_wbck.sv
//////////////////////////////////////////////////
// Write-back stage
// Retires load results in order and arbitrates
// the single register file write port
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "mini_exu_defines.svh"

module exu_wbck
  import exu_instr_pkg::*;
  import exu_track_pkg::*;
(
  input  wire              i_alu_valid,
  output logic             o_alu_ready,
  input  wire rfidx_t      i_alu_rdidx,
  input  wire xlen_t       i_alu_wdat,
  input  wire              i_lsu_valid,
  output logic             o_lsu_ready,
  input  wire itag_t       i_lsu_itag,
  input  wire xlen_t       i_lsu_wdat,
  input  wire              i_oitf_empty,
  input  wire itag_t       i_ret_ptr,
  input  wire oitf_entry_t i_ret_entry,
  output logic             o_ret_ena,
  output logic             o_rf_wen,
  output rfidx_t           o_rf_wrdidx,
  output xlen_t            o_rf_wdat
);

  logic lsu_hs;

  // Only the OITF head may come back
  assign o_lsu_ready = ~i_oitf_empty & (i_lsu_itag == i_ret_ptr);
  assign lsu_hs      = i_lsu_valid & o_lsu_ready;
  assign o_ret_ena   = lsu_hs;

  // Long pipe wins the port
  assign o_alu_ready = ~lsu_hs;

  assign o_rf_wen    = lsu_hs ? i_ret_entry.rdwen : i_alu_valid;
  assign o_rf_wrdidx = lsu_hs ? i_ret_entry.rdidx : i_alu_rdidx;
  assign o_rf_wdat   = lsu_hs ? i_lsu_wdat : i_alu_wdat;

endmodule

`default_nettype wire

// File: hw/mini_exu.sv
//////////////////////////////////////////////////
// Mini EXU top level
// Dispatch, OITF, ALU, write-back and regfile
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "mini_exu_defines.svh"

module mini_exu
  import exu_instr_pkg::*;
  import exu_track_pkg::*;
(
  input  wire          clk,
  input  wire          i_rst_n,
  // Issue from fetch
  input  wire          i_valid,
  output logic         o_ready,
  input  wire exu_op_e i_op,
  input  wire rfidx_t  i_rs1idx,
  input  wire rfidx_t  i_rs2idx,
  input  wire rfidx_t  i_rdidx,
  input  wire          i_use_imm,
  input  wire xlen_t   i_imm,
  // AGU command to the LSU
  output logic         o_agu_cmd_valid,
  input  wire          i_agu_cmd_ready,
  output xlen_t        o_agu_cmd_addr,
  output itag_t        o_agu_cmd_itag,
  // LSU write-back
  input  wire          i_lsu_wbck_valid,
  output logic         o_lsu_wbck_ready,
  input  wire xlen_t   i_lsu_wbck_wdat,
  input  wire itag_t   i_lsu_wbck_itag,
  // Status
  output xlen_t        o_x1,
  output logic         o_oitf_empty,
  output logic         o_exu_active
);

  xlen_t       rf_rs1, rf_rs2, rf_wdat, alu_op1, alu_op2, alu_result;
  rfidx_t      rf_wrdidx;
  logic        rf_wen, alu_valid, alu_wbck_ready, disp_oitf_ena, oitf_ret_ena;
  logic        oitf_full, match_rs1, match_rs2, match_rd;
  exu_op_e     alu_op;
  itag_t       oitf_ret_ptr;
  oitf_entry_t disp_oitf_entry, oitf_ret_entry;

  exu_regfile u_exu_regfile (
    .clk, .i_rst_n, .i_rs1idx, .i_rs2idx,
    .o_rs1_dat (rf_rs1), .o_rs2_dat (rf_rs2),
    .i_wen (rf_wen), .i_wrdidx (rf_wrdidx), .i_wdat (rf_wdat), .o_x1
  );

  exu_disp u_exu_disp (
    .i_valid, .o_ready, .i_op, .i_rs1idx, .i_rs2idx, .i_rdidx, .i_use_imm, .i_imm,
    .i_rs1_dat (rf_rs1), .i_rs2_dat (rf_rs2), .i_oitf_full (oitf_full),
    .i_match_rs1 (match_rs1), .i_match_rs2 (match_rs2), .i_match_rd (match_rd),
    .i_alu_wbck_ready (alu_wbck_ready), .i_agu_cmd_ready,
    .o_oitf_ena (disp_oitf_ena), .o_oitf_entry (disp_oitf_entry),
    .o_alu_valid (alu_valid), .o_alu_op (alu_op), .o_op1 (alu_op1), .o_op2 (alu_op2),
    .o_agu_cmd_valid
  );

  exu_oitf u_exu_oitf (
    .clk, .i_rst_n, .i_disp_ena (disp_oitf_ena), .i_disp_entry (disp_oitf_entry),
    .i_ret_ena (oitf_ret_ena), .i_rs1idx, .i_rs2idx, .i_rdidx,
    .o_match_rs1 (match_rs1), .o_match_rs2 (match_rs2), .o_match_rd (match_rd),
    .o_alc_ptr (o_agu_cmd_itag), .o_ret_ptr (oitf_ret_ptr),
    .o_ret_entry (oitf_ret_entry), .o_full (oitf_full), .o_empty (o_oitf_empty)
  );

  exu_alu u_exu_alu (
    .i_op (alu_op), .i_op1 (alu_op1), .i_op2 (alu_op2), .o_result (alu_result)
  );

  assign o_agu_cmd_addr = alu_result;  // Load address from the shared adder

  exu_wbck u_exu_wbck (
    .i_alu_valid (alu_valid), .o_alu_ready (alu_wbck_ready),
    .i_alu_rdidx (i_rdidx), .i_alu_wdat (alu_result),
    .i_lsu_valid (i_lsu_wbck_valid), .o_lsu_ready (o_lsu_wbck_ready),
    .i_lsu_itag (i_lsu_wbck_itag), .i_lsu_wdat (i_lsu_wbck_wdat),
    .i_oitf_empty (o_oitf_empty), .i_ret_ptr (oitf_ret_ptr),
    .i_ret_entry (oitf_ret_entry), .o_ret_ena (oitf_ret_ena),
    .o_rf_wen (rf_wen), .o_rf_wrdidx (rf_wrdidx), .o_rf_wdat (rf_wdat)
  );

  assign o_exu_active = ~o_oitf_empty | i_valid;

endmodule

`default_nettype wire

// File: tb/tb_mini_exu.sv
//////////////////////////////////////////////////
// Mini EXU testbench
// Directed tests against a register model, with
// the LSU side answered from the tests
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_mini_exu
  import exu_instr_pkg::*;
  import exu_track_pkg::*;
();

  localparam int HALF       = 20;
  localparam int SETTLE     = 10;  // Sample point after the falling edge
  localparam int MAX_CYCLES = 2000;

  logic    clk, i_rst_n, i_valid, o_ready, i_use_imm;
  exu_op_e i_op;
  rfidx_t  i_rs1idx, i_rs2idx, i_rdidx;
  xlen_t   i_imm, o_agu_cmd_addr, i_lsu_wbck_wdat, o_x1;
  logic    o_agu_cmd_valid, i_agu_cmd_ready, i_lsu_wbck_valid, o_lsu_wbck_ready;
  logic    o_oitf_empty, o_exu_active;
  itag_t   o_agu_cmd_itag, i_lsu_wbck_itag;

  xlen_t       model [32];  // Reference register contents
  xlen_t       acc_addr;    // AGU address at acceptance
  itag_t       acc_itag;
  itag_t       exp_itag  = '0;  // Next OITF allocate slot
  logic [31:0] lcg_state = 32'hb568_514b;
  int          errors    = 0;
  int          cycle_cnt = 0;

  mini_exu u_mini_exu (.*);

  always #HALF clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, a handshake never completed", cycle_cnt);
      $display("Test FAILED");
      $finish;
    end
  end

  function automatic xlen_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Expected ALU result from the op definitions
  function automatic xlen_t ref_alu(input exu_op_e op, input xlen_t a, input xlen_t b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: return '0;
    endcase
  endfunction

  task automatic report_mismatch(input string test, input xlen_t exp, input xlen_t act);
    errors++;
    $display("FAIL %s expected %h actual %h", test, exp, act);
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("Error in %s", msg);
  endtask

  // Each accepted load takes the next OITF slot
  task automatic track_itag(input string test);
    if (acc_itag !== exp_itag)
      report_mismatch({test, " itag"}, xlen_t'(exp_itag), xlen_t'(acc_itag));
    exp_itag++;
  endtask

  //////////////////////////////////////////////////
  // Bus helpers that start and end on a falling edge
  task automatic drive_op(input exu_op_e op, input rfidx_t rd, input rfidx_t rs1,
                          input rfidx_t rs2, input logic use_imm, input xlen_t imm);
    i_valid   = 1'b1;
    i_op      = op;
    i_rdidx   = rd;
    i_rs1idx  = rs1;
    i_rs2idx  = rs2;
    i_use_imm = use_imm;
    i_imm     = imm;
  endtask

  task automatic wait_accept();
    #SETTLE;
    while (!o_ready) begin
      @(negedge clk);
      #SETTLE;
    end
    acc_addr = o_agu_cmd_addr;
    acc_itag = o_agu_cmd_itag;
    @(negedge clk);
    i_valid = 1'b0;
  endtask

  task automatic drive_wbck(input itag_t tag, input xlen_t data);
    i_lsu_wbck_valid = 1'b1;
    i_lsu_wbck_itag  = tag;
    i_lsu_wbck_wdat  = data;
  endtask

  task automatic lsu_return(input itag_t tag, input xlen_t data);
    drive_wbck(tag, data);
    #SETTLE;
    while (!o_lsu_wbck_ready) begin
      @(negedge clk);
      #SETTLE;
    end
    @(negedge clk);
    i_lsu_wbck_valid = 1'b0;
  endtask

  task automatic alu_issue(input exu_op_e op, input rfidx_t rd, input rfidx_t rs1,
                           input rfidx_t rs2, input logic use_imm, input xlen_t imm);
    xlen_t res;
    res = ref_alu(op, model[rs1], use_imm ? imm : model[rs2]);
    drive_op(op, rd, rs1, rs2, use_imm, imm);
    wait_accept();
    if (rd != '0) model[rd] = res;
  endtask

  task automatic load_issue(input string test, input rfidx_t rd, input xlen_t imm);
    drive_op(OP_LD, rd, '0, '0, 1'b1, imm);
    wait_accept();
    track_itag(test);
    if (acc_addr !== imm) report_mismatch({test, " addr"}, imm, acc_addr);
  endtask

  // Read back through the AGU address with rd x0
  task automatic check_reg(input string test, input rfidx_t r);
    drive_op(OP_LD, '0, r, '0, 1'b1, '0);
    wait_accept();
    track_itag(test);
    if (acc_addr !== model[r]) report_mismatch($sformatf("%s x%0d", test, r), model[r], acc_addr);
    lsu_return(acc_itag, next_rand());
  endtask

  //////////////////////////////////////////////////
  // Tests
  task automatic test_reset();
    #SETTLE;
    if (o_oitf_empty !== 1'b1) report_error("reset, OITF not empty");
    if (o_exu_active !== 1'b0) report_error("reset, o_exu_active high while idle");
    if (o_agu_cmd_valid !== 1'b0) report_error("reset, AGU command valid with no load");
    if (o_lsu_wbck_ready !== 1'b0) report_error("reset, write-back ready with no load");
    if (o_x1 !== '0) report_mismatch("reset o_x1", '0, o_x1);
    @(negedge clk);
  endtask

  task automatic test_alu();
    exu_op_e op;
    for (int r = 1; r < 8; r++) alu_issue(OP_ADD, rfidx_t'(r), '0, '0, 1'b1, next_rand());
    for (int k = 0; k < 6; k++) begin
      op = exu_op_e'(k);
      alu_issue(op, rfidx_t'(8 + k), rfidx_t'(1 + k), rfidx_t'(2 + k), 1'b0, '0);
      check_reg("alu_reg", rfidx_t'(8 + k));
      alu_issue(op, rfidx_t'(14 + k), rfidx_t'(1 + k), '0, 1'b1, next_rand());
      check_reg("alu_imm", rfidx_t'(14 + k));
    end
    alu_issue(OP_SLT, 5'd20, '0, '0, 1'b1, 32'hffff_fff0);  // 0 < -16 is false
    check_reg("alu_slt", 5'd20);
    alu_issue(OP_SLT, 5'd21, '0, '0, 1'b1, 32'd5);
    check_reg("alu_slt", 5'd21);
    alu_issue(OP_SUB, 5'd1, 5'd2, 5'd3, 1'b0, '0);
    if (o_x1 !== model[1]) report_mismatch("alu o_x1", model[1], o_x1);
    check_reg("alu_x1", 5'd1);
    alu_issue(OP_ADD, '0, 5'd1, '0, 1'b1, 32'h55);
    check_reg("alu_x0", '0);
  endtask

  task automatic test_hazard();
    xlen_t data;
    itag_t tag;
    data = next_rand();
    load_issue("hazard", 5'd5, next_rand());
    tag = acc_itag;
    drive_op(OP_ADD, 5'd6, 5'd5, 5'd2, 1'b0, '0);
    repeat (3) begin
      #SETTLE;
      if (o_ready !== 1'b0) report_error("hazard, op reading x5 not stalled");
      if (o_exu_active !== 1'b1) report_error("hazard, o_exu_active low with a load in flight");
      @(negedge clk);
    end
    lsu_return(tag, data);  // Op still stalled in the handshake cycle
    model[5] = data;
    wait_accept();
    model[6] = data + model[2];
    check_reg("hazard", 5'd6);
    check_reg("hazard", 5'd5);
  endtask

  task automatic test_full();
    itag_t tags [4];
    xlen_t data [5];
    itag_t tag5;
    for (int k = 0; k < 5; k++) data[k] = next_rand();
    for (int k = 0; k < 4; k++) begin
      load_issue("oitf_full", rfidx_t'(10 + k), next_rand());
      tags[k] = acc_itag;
    end
    drive_op(OP_LD, 5'd14, '0, '0, 1'b1, 32'h40);
    #SETTLE;
    if (o_ready !== 1'b0) report_error("oitf_full, fifth load accepted");
    if (o_agu_cmd_valid !== 1'b0) report_error("oitf_full, command valid with OITF full");
    @(negedge clk);
    alu_issue(OP_XOR, 5'd15, 5'd1, 5'd2, 1'b0, '0);  // Independent op must not stall
    drive_wbck(tags[1], data[1]);
    #SETTLE;
    if (o_lsu_wbck_ready !== 1'b0) report_error("oitf_full, non-head itag accepted");
    @(negedge clk);
    i_lsu_wbck_valid = 1'b0;
    lsu_return(tags[0], data[0]);
    model[10] = data[0];
    load_issue("oitf_full", 5'd14, 32'h40);
    tag5 = acc_itag;
    for (int k = 1; k < 4; k++) begin
      lsu_return(tags[k], data[k]);
      model[10 + k] = data[k];
    end
    lsu_return(tag5, data[4]);
    model[14] = data[4];
    for (int r = 10; r < 16; r++) check_reg("oitf_full", rfidx_t'(r));
  endtask

  task automatic test_backpressure();
    xlen_t imm, data;
    itag_t tag;
    imm  = next_rand();
    data = next_rand();
    i_agu_cmd_ready = 1'b0;
    drive_op(OP_LD, 5'd20, '0, '0, 1'b1, imm);
    repeat (3) begin
      #SETTLE;
      if (o_ready !== 1'b0) report_error("backpressure, load accepted without AGU ready");
      if (o_agu_cmd_valid !== 1'b1) report_error("backpressure, command valid dropped");
      @(negedge clk);
    end
    if (o_oitf_empty !== 1'b1) report_error("backpressure, OITF allocated without handshake");
    i_agu_cmd_ready = 1'b1;
    wait_accept();
    track_itag("backpressure");
    if (acc_addr !== imm) report_mismatch("backpressure addr", imm, acc_addr);
    tag = acc_itag;
    // Write-back and ALU op offered in the same cycle
    drive_op(OP_ADD, 5'd21, 5'd1, 5'd2, 1'b0, '0);
    drive_wbck(tag, data);
    #SETTLE;
    if (o_lsu_wbck_ready !== 1'b1) report_error("priority, head write-back not ready");
    if (o_ready !== 1'b0) report_error("priority, ALU op accepted during write-back");
    @(negedge clk);
    i_lsu_wbck_valid = 1'b0;
    model[20] = data;
    wait_accept();
    model[21] = model[1] + model[2];
    check_reg("priority", 5'd21);
    check_reg("priority", 5'd20);
  endtask

  initial begin
    clk = 1'b0;
    i_rst_n = 1'b0;
    drive_op(OP_ADD, '0, '0, '0, 1'b0, '0);
    i_valid = 1'b0;
    i_agu_cmd_ready = 1'b1;
    drive_wbck('0, '0);
    i_lsu_wbck_valid = 1'b0;
    for (int r = 0; r < 32; r++) model[r] = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    i_rst_n = 1'b1;
    test_reset();
    test_alu();
    test_hazard();
    test_full();
    test_backpressure();
    $display("Run complete after %0d cycles, %0d errors", cycle_cnt, errors);
    if (errors == 0) $display("Test OK");
    else $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: mini_exu.f
+incdir+common
common/exu_instr_pkg.sv
common/exu_track_pkg.sv
hw/exu_regfile.sv
disp/exu_disp.sv
oitf/exu_oitf.sv
hw/exu_alu.sv
wbck/exu_wbck.sv
hw/mini_exu.sv
tb/tb_mini_exu.sv

// File: Bender.yml
package:
  name: mini_exu

export_include_dirs:
  - common

sources:
  - common/exu_instr_pkg.sv
  - common/exu_track_pkg.sv
  - hw/exu_regfile.sv
  - disp/exu_disp.sv
  - oitf/exu_oitf.sv
  - hw/exu_alu.sv
  - wbck/exu_wbck.sv
  - hw/mini_exu.sv
  - target: simulation
    files:
      - tb/tb_mini_exu.sv
